//--- build.f
common/cpu_pkg.sv
common/decode_if.sv
decode/inst_decoder.sv
execute/alu.sv
execute/exec_unit.sv
source/fetch_control.sv
source/regfile.sv
source/result_writeback.sv
source/la32_core_top.sv
verif/la32_tb.sv

//--- common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // Boot address of the core
    localparam word_t RESET_PC_DEFAULT = 32'h1c00_0000;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLT,
        SLTU,
        AND,
        NOR,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        LUI
    } alu_op_e;

    // Steers the state machine after EXECUTE
    typedef enum logic [2:0] {
        ALU,
        BRANCH,
        LOAD,
        STORE,
        NOP
    } inst_kind_e;

    typedef enum logic [2:0] {
        NONE,
        B,
        BL,
        BEQ,
        BNE,
        JIRL
    } br_kind_e;

endpackage

`default_nettype wire

//--- common/decode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_if;

    cpu_pkg::inst_kind_e kind;
    cpu_pkg::br_kind_e   br_kind;
    cpu_pkg::alu_op_e    alu_op;
    logic                src1_is_pc;
    logic                src2_is_imm;
    cpu_pkg::word_t      imm;
    cpu_pkg::word_t      br_offs;
    cpu_pkg::reg_addr_t  rj;
    cpu_pkg::reg_addr_t  rkd;
    cpu_pkg::reg_addr_t  dest;
    logic                gr_we;

    modport dec (
        output kind, br_kind, alu_op, src1_is_pc, src2_is_imm,
        output imm, br_offs, rj, rkd, dest, gr_we
    );

    modport exe (
        input kind, br_kind, alu_op, src1_is_pc, src2_is_imm,
        input imm, br_offs, rj, rkd
    );

    modport ctl (
        input kind, dest, gr_we
    );

endinterface

`default_nettype wire

//--- decode/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  cpu_pkg::word_t inst,
    decode_if.dec          dec
);

    logic src2_is_4;
    logic need_si20;
    logic need_si26;
    logic src_reg_is_rd;
    logic dst_is_r1;

    always_comb begin
        dec.kind        = cpu_pkg::NOP;
        dec.br_kind     = cpu_pkg::NONE;
        dec.alu_op      = cpu_pkg::ADD;
        dec.src1_is_pc  = 1'b0;
        dec.src2_is_imm = 1'b0;
        dec.gr_we       = 1'b0;
        src2_is_4       = 1'b0;
        need_si20       = 1'b0;
        need_si26       = 1'b0;
        src_reg_is_rd   = 1'b0;
        dst_is_r1       = 1'b0;
        case (inst[31:26])
            6'h00: begin
                // 3R format
                if (inst[25:20] == 6'h01) begin
                    dec.kind  = cpu_pkg::ALU;
                    dec.gr_we = 1'b1;
                    case (inst[19:15])
                        5'h00:   dec.alu_op = cpu_pkg::ADD;
                        5'h02:   dec.alu_op = cpu_pkg::SUB;
                        5'h04:   dec.alu_op = cpu_pkg::SLT;
                        5'h05:   dec.alu_op = cpu_pkg::SLTU;
                        5'h08:   dec.alu_op = cpu_pkg::NOR;
                        5'h09:   dec.alu_op = cpu_pkg::AND;
                        5'h0a:   dec.alu_op = cpu_pkg::OR;
                        5'h0b:   dec.alu_op = cpu_pkg::XOR;
                        default: begin
                            dec.kind  = cpu_pkg::NOP;
                            dec.gr_we = 1'b0;
                        end
                    endcase
                end else if (inst[25:20] == 6'h04) begin
                    dec.kind        = cpu_pkg::ALU;
                    dec.gr_we       = 1'b1;
                    dec.src2_is_imm = 1'b1;
                    case (inst[19:15])
                        5'h01:   dec.alu_op = cpu_pkg::SLL;
                        5'h09:   dec.alu_op = cpu_pkg::SRL;
                        5'h11:   dec.alu_op = cpu_pkg::SRA;
                        default: begin
                            dec.kind  = cpu_pkg::NOP;
                            dec.gr_we = 1'b0;
                        end
                    endcase
                end else if (inst[25:22] == 4'ha) begin
                    dec.kind        = cpu_pkg::ALU;
                    dec.gr_we       = 1'b1;
                    dec.src2_is_imm = 1'b1;
                end
            end
            6'h05: begin
                if (!inst[25]) begin
                    dec.kind        = cpu_pkg::ALU;
                    dec.alu_op      = cpu_pkg::LUI;
                    dec.gr_we       = 1'b1;
                    dec.src2_is_imm = 1'b1;
                    need_si20       = 1'b1;
                end
            end
            6'h0a: begin
                if (inst[25:22] == 4'h2) begin
                    dec.kind        = cpu_pkg::LOAD;
                    dec.gr_we       = 1'b1;
                    dec.src2_is_imm = 1'b1;
                end else if (inst[25:22] == 4'h6) begin
                    dec.kind        = cpu_pkg::STORE;
                    dec.src2_is_imm = 1'b1;
                    src_reg_is_rd   = 1'b1;
                end
            end
            // Linking jumps compute PC+4 in the ALU and go through writeback
            6'h13, 6'h15: begin
                dec.kind        = cpu_pkg::ALU;
                dec.br_kind     = (inst[28]) ? cpu_pkg::BL : cpu_pkg::JIRL;
                dec.gr_we       = 1'b1;
                dec.src1_is_pc  = 1'b1;
                dec.src2_is_imm = 1'b1;
                src2_is_4       = 1'b1;
                need_si26       = inst[28];
                dst_is_r1       = inst[28];
            end
            6'h14: begin
                dec.kind    = cpu_pkg::BRANCH;
                dec.br_kind = cpu_pkg::B;
                need_si26   = 1'b1;
            end
            6'h16, 6'h17: begin
                dec.kind      = cpu_pkg::BRANCH;
                dec.br_kind   = (inst[26]) ? cpu_pkg::BNE : cpu_pkg::BEQ;
                src_reg_is_rd = 1'b1;
            end
            default: ;
        endcase
    end

    assign dec.imm = src2_is_4 ? 32'd4 :
                     need_si20 ? {inst[24:5], 12'b0} :
                                 {{20{inst[21]}}, inst[21:10]};

    assign dec.br_offs = need_si26 ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0} :
                                     {{14{inst[25]}}, inst[25:10], 2'b0};

    assign dec.rj   = inst[9:5];
    assign dec.rkd  = src_reg_is_rd ? inst[4:0] : inst[14:10];
    assign dec.dest = dst_is_r1 ? 5'd1 : inst[4:0];

endmodule

`default_nettype wire

//--- execute/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  cpu_pkg::alu_op_e alu_op,
    input  cpu_pkg::word_t   src1,
    input  cpu_pkg::word_t   src2,
    output cpu_pkg::word_t   result
);

    logic [4:0] shamt;

    assign shamt = src2[4:0];

    always_comb begin
        case (alu_op)
            cpu_pkg::ADD: begin
                result = src1 + src2;
            end
            cpu_pkg::SUB: begin
                result = src1 - src2;
            end
            cpu_pkg::SLT: begin
                result = {31'b0, $signed(src1) < $signed(src2)};
            end
            cpu_pkg::SLTU: begin
                result = {31'b0, src1 < src2};
            end
            cpu_pkg::AND:  result = src1 & src2;
            cpu_pkg::NOR:  result = ~(src1 | src2);
            cpu_pkg::OR:   result = src1 | src2;
            cpu_pkg::XOR:  result = src1 ^ src2;
            cpu_pkg::SLL:  result = src1 << shamt;
            cpu_pkg::SRL:  result = src1 >> shamt;
            cpu_pkg::SRA: begin
                result = $signed(src1) >>> shamt;
            end
            // Upper immediate already shifted by the decoder
            cpu_pkg::LUI:  result = src2;
            default:       result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- execute/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  logic           clk,
    input  logic           reset,
    input  logic           state_exe,
    input  cpu_pkg::word_t pc,
    input  cpu_pkg::word_t rj_value,
    input  cpu_pkg::word_t rkd_value,
    decode_if.exe          exe,
    output cpu_pkg::word_t alu_result,
    output cpu_pkg::word_t next_pc
);

    cpu_pkg::word_t src1;
    cpu_pkg::word_t src2;
    cpu_pkg::word_t alu_out;
    cpu_pkg::word_t br_target;
    cpu_pkg::word_t next_pc_d;
    cpu_pkg::word_t next_pc_q;
    logic           rj_eq_rd;
    logic           br_taken;

    assign src1 = exe.src1_is_pc ? pc : rj_value;
    assign src2 = exe.src2_is_imm ? exe.imm : rkd_value;

    alu alu_i (
        .alu_op (exe.alu_op),
        .src1   (src1),
        .src2   (src2),
        .result (alu_out)
    );

    assign rj_eq_rd = (rj_value == rkd_value);

    always_comb begin
        case (exe.br_kind)
            cpu_pkg::B, cpu_pkg::BL, cpu_pkg::JIRL: br_taken = 1'b1;
            cpu_pkg::BEQ: br_taken = rj_eq_rd;
            cpu_pkg::BNE: br_taken = !rj_eq_rd;
            default:      br_taken = 1'b0;
        endcase
    end

    // jirl is register relative, the rest are PC relative
    assign br_target = (exe.br_kind == cpu_pkg::JIRL) ? rj_value + exe.br_offs :
                                                        pc + exe.br_offs;
    assign next_pc_d = br_taken ? br_target : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_result <= '0;
            next_pc_q  <= '0;
        end else if (state_exe) begin
            alu_result <= alu_out;
            next_pc_q  <= next_pc_d;
        end
    end

    // Branches retire straight out of EXECUTE and need the value this cycle
    assign next_pc = state_exe ? next_pc_d : next_pc_q;

endmodule

`default_nettype wire

//--- source/fetch_control.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_control #(
    parameter cpu_pkg::word_t RESET_PC = cpu_pkg::RESET_PC_DEFAULT
) (
    input  logic           clk,
    input  logic           reset,
    output logic           inst_sram_en,
    output cpu_pkg::word_t inst_sram_addr,
    input  cpu_pkg::word_t inst_sram_rdata,
    output logic           data_sram_en,
    output logic           data_sram_we,
    input  cpu_pkg::word_t next_pc,
    output cpu_pkg::word_t inst,
    output cpu_pkg::word_t pc,
    output logic           state_exe,
    output logic           state_wb,
    decode_if.ctl          ctl
);

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK
    } state_e;

    state_e state;
    state_e state_next;
    logic   valid;

    // Holds off the first fetch until reset has been seen low
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else begin
            valid <= 1'b1;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            FETCH:     if (valid) state_next = DECODE;
            DECODE:    state_next = EXECUTE;
            EXECUTE: begin
                case (ctl.kind)
                    cpu_pkg::ALU:                 state_next = WRITEBACK;
                    cpu_pkg::LOAD, cpu_pkg::STORE: state_next = MEMORY;
                    default:                      state_next = FETCH;
                endcase
            end
            MEMORY:    state_next = (ctl.kind == cpu_pkg::LOAD) ? WRITEBACK : FETCH;
            WRITEBACK: state_next = FETCH;
            default:   state_next = FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            pc    <= RESET_PC;
        end else begin
            state <= state_next;
            if (state != FETCH && state_next == FETCH) begin
                pc <= next_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == DECODE) begin
            inst <= inst_sram_rdata;
        end
    end

    assign inst_sram_en   = valid && (state == FETCH);
    assign inst_sram_addr = pc;
    assign data_sram_en   = (state == MEMORY);
    assign data_sram_we   = (state == MEMORY) && (ctl.kind == cpu_pkg::STORE);
    assign state_exe      = (state == EXECUTE);
    assign state_wb       = (state == WRITEBACK);

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK});

    // A data access always follows EXECUTE of a load or store
    a_data_en_mem: assert property (@(posedge clk) disable iff (reset)
        data_sram_en |-> $past(state) == EXECUTE
                         && ctl.kind inside {cpu_pkg::LOAD, cpu_pkg::STORE});

endmodule

`default_nettype wire

//--- source/la32_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module la32_core_top #(
    parameter cpu_pkg::word_t RESET_PC = cpu_pkg::RESET_PC_DEFAULT
) (
    input  logic               clk,
    input  logic               reset,
    output logic               inst_sram_en,
    output cpu_pkg::word_t     inst_sram_addr,
    input  cpu_pkg::word_t     inst_sram_rdata,
    output logic               data_sram_en,
    output logic               data_sram_we,
    output cpu_pkg::word_t     data_sram_addr,
    output cpu_pkg::word_t     data_sram_wdata,
    input  cpu_pkg::word_t     data_sram_rdata,
    output cpu_pkg::word_t     debug_wb_pc,
    output logic [3:0]         debug_wb_rf_we,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum,
    output cpu_pkg::word_t     debug_wb_rf_wdata
);

    cpu_pkg::word_t     inst;
    cpu_pkg::word_t     pc;
    cpu_pkg::word_t     next_pc;
    cpu_pkg::word_t     alu_result;
    cpu_pkg::word_t     rj_value;
    cpu_pkg::word_t     rkd_value;
    logic               state_exe;
    logic               state_wb;
    logic               rf_we;
    cpu_pkg::reg_addr_t rf_waddr;
    cpu_pkg::word_t     rf_wdata;

    decode_if dec_if ();

    fetch_control #(
        .RESET_PC (RESET_PC)
    ) fetch_control_i (
        .clk             (clk),
        .reset           (reset),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .next_pc         (next_pc),
        .inst            (inst),
        .pc              (pc),
        .state_exe       (state_exe),
        .state_wb        (state_wb),
        .ctl             (dec_if.ctl)
    );

    inst_decoder inst_decoder_i (
        .inst (inst),
        .dec  (dec_if.dec)
    );

    regfile regfile_i (
        .clk    (clk),
        .raddr1 (dec_if.rj),
        .raddr2 (dec_if.rkd),
        .rdata1 (rj_value),
        .rdata2 (rkd_value),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    exec_unit exec_unit_i (
        .clk        (clk),
        .reset      (reset),
        .state_exe  (state_exe),
        .pc         (pc),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .exe        (dec_if.exe),
        .alu_result (alu_result),
        .next_pc    (next_pc)
    );

    result_writeback result_writeback_i (
        .clk               (clk),
        .reset             (reset),
        .state_wb          (state_wb),
        .pc                (pc),
        .alu_result        (alu_result),
        .data_sram_rdata   (data_sram_rdata),
        .ctl               (dec_if.ctl),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = rkd_value;

endmodule

`default_nettype wire

//--- source/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic               clk,
    input  cpu_pkg::reg_addr_t raddr1,
    input  cpu_pkg::reg_addr_t raddr2,
    output cpu_pkg::word_t     rdata1,
    output cpu_pkg::word_t     rdata2,
    input  logic               we,
    input  cpu_pkg::reg_addr_t waddr,
    input  cpu_pkg::word_t     wdata
);

    cpu_pkg::word_t rf [32];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 is hardwired to zero
    assign rdata1 = (raddr1 == 5'd0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : rf[raddr2];

endmodule

`default_nettype wire

//--- source/result_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module result_writeback (
    input  logic               clk,
    input  logic               reset,
    input  logic               state_wb,
    input  cpu_pkg::word_t     pc,
    input  cpu_pkg::word_t     alu_result,
    input  cpu_pkg::word_t     data_sram_rdata,
    decode_if.ctl              ctl,
    output logic               rf_we,
    output cpu_pkg::reg_addr_t rf_waddr,
    output cpu_pkg::word_t     rf_wdata,
    output cpu_pkg::word_t     debug_wb_pc,
    output logic [3:0]         debug_wb_rf_we,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum,
    output cpu_pkg::word_t     debug_wb_rf_wdata
);

    // Load data arrives from the SRAM during WRITEBACK
    assign rf_wdata = (ctl.kind == cpu_pkg::LOAD) ? data_sram_rdata : alu_result;
    assign rf_waddr = ctl.dest;
    assign rf_we    = state_wb && ctl.gr_we && (ctl.dest != 5'd0);

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

    // One write per retired instruction
    a_we_single: assert property (@(posedge clk) disable iff (reset)
        rf_we |-> state_wb && !$past(state_wb));

endmodule

`default_nettype wire

//--- verif/la32_tb.sv
`timescale 1ns/1ps
`default_nettype none

module la32_tb;

    localparam cpu_pkg::word_t RESET_PC = 32'h1c00_0000;
    localparam int RUN_TIMEOUT = 600;

    logic                   clk;
    logic                   reset;
    logic                   inst_sram_en;
    cpu_pkg::word_t         inst_sram_addr;
    cpu_pkg::word_t         inst_sram_rdata;
    logic                   data_sram_en;
    logic                   data_sram_we;
    cpu_pkg::word_t         data_sram_addr;
    cpu_pkg::word_t         data_sram_wdata;
    cpu_pkg::word_t         data_sram_rdata;
    cpu_pkg::word_t         debug_wb_pc;
    logic [3:0]             debug_wb_rf_we;
    cpu_pkg::reg_addr_t     debug_wb_rf_wnum;
    cpu_pkg::word_t         debug_wb_rf_wdata;

    cpu_pkg::word_t         imem [1024];
    cpu_pkg::word_t         dmem [1024];
    cpu_pkg::word_t         ref_dmem [1024];
    cpu_pkg::word_t         ref_rf [32];
    cpu_pkg::word_t         prog [$];
    cpu_pkg::word_t         exp_pc [$];
    cpu_pkg::reg_addr_t     exp_rd [$];
    cpu_pkg::word_t         exp_data [$];
    cpu_pkg::word_t         trace_pc [$];
    cpu_pkg::reg_addr_t     trace_rd [$];
    cpu_pkg::word_t         trace_data [$];
    cpu_pkg::word_t         bpc;
    int                     dwrite_cnt;
    int                     value_errors;
    int                     timeout_errors;
    int                     other_errors;

    la32_core_top #(
        .RESET_PC (RESET_PC)
    ) la32_core_top_i (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #2 clk = ~clk;

    // SRAM models, one cycle read latency
    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_sram_rdata <= #1 imem[inst_sram_addr[11:2]];
        end
    end

    always @(posedge clk) begin
        if (data_sram_en && data_sram_we) begin
            dmem[data_sram_addr[11:2]] = data_sram_wdata;
            dwrite_cnt++;
        end else if (data_sram_en) begin
            data_sram_rdata <= #1 dmem[data_sram_addr[11:2]];
        end
    end

    // Trace capture
    always @(posedge clk) begin
        if (!reset && debug_wb_rf_we != 4'h0) begin
            trace_pc.push_back(debug_wb_pc);
            trace_rd.push_back(debug_wb_rf_wnum);
            trace_data.push_back(debug_wb_rf_wdata);
        end
    end

    task automatic check_word(input string what, input cpu_pkg::word_t got,
                              input cpu_pkg::word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_reg(input string what, input cpu_pkg::reg_addr_t got,
                             input cpu_pkg::reg_addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED at %0t: %s is r%0d, expected r%0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    function automatic cpu_pkg::word_t fill_pattern(input int idx);
        return 32'hc3a5_0f1e ^ (idx * 32'h9e37_79b9);
    endfunction

    // Instruction encoders
    function automatic cpu_pkg::word_t inst_3r(input logic [4:0] func,
        input cpu_pkg::reg_addr_t rd, input cpu_pkg::reg_addr_t rj,
        input cpu_pkg::reg_addr_t rk);
        return {6'h00, 6'h01, func, rk, rj, rd};
    endfunction

    function automatic cpu_pkg::word_t shift_inst(input logic [4:0] func,
        input cpu_pkg::reg_addr_t rd, input cpu_pkg::reg_addr_t rj, input logic [4:0] ui5);
        return {6'h00, 6'h04, func, ui5, rj, rd};
    endfunction

    function automatic cpu_pkg::word_t ri12_inst(input logic [9:0] op,
        input cpu_pkg::reg_addr_t rd, input cpu_pkg::reg_addr_t rj, input logic [11:0] si12);
        return {op, si12, rj, rd};
    endfunction

    function automatic cpu_pkg::word_t lu12i_inst(input cpu_pkg::reg_addr_t rd,
                                                  input logic [19:0] si20);
        return {7'h0a, si20, rd};
    endfunction

    function automatic cpu_pkg::word_t branch16(input logic [5:0] op,
        input cpu_pkg::reg_addr_t rd, input cpu_pkg::reg_addr_t rj, input logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    function automatic cpu_pkg::word_t branch26(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    // Reference results
    function automatic cpu_pkg::word_t reg_op_result(input logic [4:0] func,
        input cpu_pkg::word_t a, input cpu_pkg::word_t b);
        case (func)
            5'h00:   return a + b;
            5'h02:   return a - b;
            5'h04:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            5'h05:   return (a < b) ? 32'd1 : 32'd0;
            5'h08:   return ~(a | b);
            5'h09:   return a & b;
            5'h0a:   return a | b;
            5'h0b:   return a ^ b;
            default: return 'x;
        endcase
    endfunction

    function automatic cpu_pkg::word_t shift_result(input logic [4:0] func,
        input cpu_pkg::word_t a, input logic [4:0] sh);
        case (func)
            5'h01:   return a << sh;
            5'h09:   return a >> sh;
            5'h11:   return $signed(a) >>> sh;
            default: return 'x;
        endcase
    endfunction

    task automatic append_inst(input cpu_pkg::word_t w);
        prog.push_back(w);
        bpc = bpc + 32'd4;
    endtask

    task automatic retire_write(input cpu_pkg::word_t w, input cpu_pkg::reg_addr_t rd,
                                input cpu_pkg::word_t value);
        // r0 writes leave no trace
        if (rd != 5'd0) begin
            exp_pc.push_back(bpc);
            exp_rd.push_back(rd);
            exp_data.push_back(value);
            ref_rf[rd] = value;
        end
        append_inst(w);
    endtask

    task automatic alu_reg(input logic [4:0] func, input cpu_pkg::reg_addr_t rd,
                           input cpu_pkg::reg_addr_t rj, input cpu_pkg::reg_addr_t rk);
        retire_write(inst_3r(func, rd, rj, rk), rd, reg_op_result(func, ref_rf[rj], ref_rf[rk]));
    endtask

    task automatic shift_imm(input logic [4:0] func, input cpu_pkg::reg_addr_t rd,
                             input cpu_pkg::reg_addr_t rj, input logic [4:0] ui5);
        retire_write(shift_inst(func, rd, rj, ui5), rd, shift_result(func, ref_rf[rj], ui5));
    endtask

    task automatic add_imm(input cpu_pkg::reg_addr_t rd, input cpu_pkg::reg_addr_t rj,
                           input logic [11:0] si12);
        retire_write(ri12_inst(10'h00a, rd, rj, si12), rd,
                     ref_rf[rj] + {{20{si12[11]}}, si12});
    endtask

    task automatic upper_imm(input cpu_pkg::reg_addr_t rd, input logic [19:0] si20);
        retire_write(lu12i_inst(rd, si20), rd, {si20, 12'h000});
    endtask

    task automatic load_const(input cpu_pkg::reg_addr_t rd, input cpu_pkg::word_t value);
        cpu_pkg::word_t hi;
        // Round up so the signed low part lands on the value
        hi = value + 32'h800;
        upper_imm(rd, hi[31:12]);
        add_imm(rd, rd, value[11:0]);
    endtask

    task automatic store_word(input cpu_pkg::reg_addr_t rd, input cpu_pkg::reg_addr_t rj,
                              input logic [11:0] si12);
        cpu_pkg::word_t addr;
        addr = ref_rf[rj] + {{20{si12[11]}}, si12};
        ref_dmem[addr[11:2]] = ref_rf[rd];
        append_inst(ri12_inst(10'h0a6, rd, rj, si12));
    endtask

    task automatic load_word(input cpu_pkg::reg_addr_t rd, input cpu_pkg::reg_addr_t rj,
                             input logic [11:0] si12);
        cpu_pkg::word_t addr;
        addr = ref_rf[rj] + {{20{si12[11]}}, si12};
        retire_write(ri12_inst(10'h0a2, rd, rj, si12), rd, ref_dmem[addr[11:2]]);
    endtask

    task automatic new_program;
        prog.delete();
        exp_pc.delete();
        exp_rd.delete();
        exp_data.delete();
        bpc = RESET_PC;
        for (int i = 0; i < 1024; i++) begin
            ref_dmem[i] = fill_pattern(i);
        end
    endtask

    // Self loop keeps the core quiet after the program
    task automatic end_program;
        append_inst(branch26(6'h14, 26'd0));
    endtask

    task automatic strobes_low(input string when);
        check_flag({"inst_sram_en ", when}, inst_sram_en, 1'b0);
        check_flag({"data_sram_en ", when}, data_sram_en, 1'b0);
        check_flag({"data_sram_we ", when}, data_sram_we, 1'b0);
        check_flag({"debug_wb_rf_we ", when}, |debug_wb_rf_we, 1'b0);
    endtask

    task automatic run_program(input string name);
        int cyc;
        int n;
        $display("Running %s", name);
        @(posedge clk);
        #1;
        reset = 1'b1;
        for (int i = 0; i < 1024; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : fill_pattern(i);
            dmem[i] = fill_pattern(i);
        end
        repeat (8) begin
            @(posedge clk);
            #1;
            strobes_low("in reset");
        end
        trace_pc.delete();
        trace_rd.delete();
        trace_data.delete();
        dwrite_cnt = 0;
        reset = 1'b0;
        strobes_low("after reset");
        cyc = 0;
        while (!inst_sram_en && cyc < 10) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        if (!inst_sram_en) begin
            timeout_errors++;
            $display("Timeout: no instruction fetch after reset in %s", name);
        end else begin
            check_word("first fetch address", inst_sram_addr, RESET_PC);
        end
        cyc = 0;
        while (trace_pc.size() < exp_pc.size() && cyc < RUN_TIMEOUT) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        if (trace_pc.size() < exp_pc.size()) begin
            timeout_errors++;
            $display("Timeout: %0d of %0d register writes seen in %s",
                     trace_pc.size(), exp_pc.size(), name);
        end
        // Quiet window to catch stray writes
        repeat (20) begin
            @(posedge clk);
        end
        #1;
        if (trace_pc.size() != exp_pc.size()) begin
            other_errors++;
            $display("%s made %0d register writes instead of %0d",
                     name, trace_pc.size(), exp_pc.size());
        end
        n = (trace_pc.size() < exp_pc.size()) ? trace_pc.size() : exp_pc.size();
        for (int i = 0; i < n; i++) begin
            check_word($sformatf("write %0d pc", i), trace_pc[i], exp_pc[i]);
            check_reg($sformatf("write %0d register", i), trace_rd[i], exp_rd[i]);
            check_word($sformatf("write %0d data", i), trace_data[i], exp_data[i]);
        end
        for (int i = 0; i < 1024; i++) begin
            check_word($sformatf("data word %0d", i), dmem[i], ref_dmem[i]);
        end
    endtask

    task automatic reset_behavior;
        new_program();
        add_imm(4, 0, 12'h123);
        end_program();
        run_program("reset");
    endtask

    task automatic register_alu_ops;
        logic [39:0]    funcs;
        cpu_pkg::word_t a;
        funcs = {5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09, 5'h0a, 5'h0b};
        new_program();
        for (int pass = 0; pass < 2; pass++) begin
            a = $urandom();
            // Opposite signs on the second pass
            if (pass == 1) begin
                a = a | 32'h8000_0000;
            end
            load_const(4, a);
            load_const(5, (pass == 1) ? ($urandom() & 32'h7fff_ffff) : $urandom());
            for (int i = 0; i < 8; i++) begin
                alu_reg(funcs[5*i +: 5], 6 + i, 4, 5);
            end
        end
        end_program();
        run_program("register ALU ops");
    endtask

    task automatic immediate_ops;
        logic [11:0] si;
        logic [19:0] upper;
        si = $urandom() % 4096;
        upper = $urandom() % 1048576;
        new_program();
        load_const(4, $urandom());
        load_const(8, $urandom() | 32'h8000_0000);
        shift_imm(5'h01, 7, 4, $urandom() % 32);
        shift_imm(5'h09, 9, 8, $urandom() % 32);
        shift_imm(5'h11, 10, 8, $urandom() % 32);
        shift_imm(5'h11, 11, 4, $urandom() % 32);
        add_imm(12, 4, si);
        add_imm(14, 0, 12'h800);
        upper_imm(13, upper);
        add_imm(0, 4, 12'h005);
        shift_imm(5'h01, 0, 4, 5'd3);
        add_imm(15, 0, 12'h7ff);
        end_program();
        run_program("immediate ops");
    endtask

    task automatic store_then_load;
        new_program();
        load_const(12, 32'h0000_0100);
        load_const(13, $urandom());
        load_const(14, $urandom());
        store_word(13, 12, 12'h008);
        store_word(14, 12, 12'hffc);
        load_word(15, 12, 12'h008);
        load_word(16, 12, 12'hffc);
        load_word(17, 0, 12'h100);
        end_program();
        run_program("store and load");
    endtask

    task automatic branch_sequence;
        new_program();
        load_const(4, 32'h1234_5678);
        load_const(5, 32'h1234_5678);
        load_const(6, 32'h8765_4321);
        append_inst(branch16(6'h16, 5, 4, 16'd2));
        append_inst(ri12_inst(10'h00a, 7, 0, 12'd1));
        append_inst(branch16(6'h16, 6, 4, 16'd2));
        add_imm(7, 0, 12'd2);
        append_inst(branch16(6'h17, 6, 4, 16'd2));
        append_inst(ri12_inst(10'h00a, 7, 0, 12'd3));
        append_inst(branch16(6'h17, 5, 4, 16'd2));
        add_imm(8, 0, 12'd4);
        append_inst(branch26(6'h14, 26'd2));
        append_inst(ri12_inst(10'h00a, 7, 0, 12'd5));
        // bl links to r1
        retire_write(branch26(6'h15, 26'd2), 1, bpc + 32'd4);
        append_inst(ri12_inst(10'h00a, 7, 0, 12'd6));
        load_const(9, RESET_PC + 32'd88);
        retire_write(branch16(6'h13, 10, 9, 16'd0), 10, bpc + 32'd4);
        append_inst(ri12_inst(10'h00a, 7, 0, 12'd7));
        add_imm(11, 0, 12'd8);
        end_program();
        run_program("control flow");
    endtask

    task automatic unknown_encoding;
        new_program();
        load_const(4, $urandom());
        append_inst(32'hffff_ffff);
        append_inst(32'h0000_0000);
        add_imm(5, 4, 12'h001);
        end_program();
        run_program("unknown encoding");
        if (dwrite_cnt != 0) begin
            other_errors++;
            $display("Unknown encodings caused %0d data memory writes", dwrite_cnt);
        end
    endtask

    initial begin
        void'($urandom(32'h451e));
        clk = 1'b0;
        reset = 1'b1;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        dwrite_cnt = 0;
        value_errors = 0;
        timeout_errors = 0;
        other_errors = 0;
        ref_rf[0] = '0;
        reset_behavior();
        register_alu_ops();
        immediate_ops();
        store_then_load();
        branch_sequence();
        unknown_encoding();
        $display("Errors: %0d wrong values, %0d timeouts, %0d other",
                 value_errors, timeout_errors, other_errors);
        if (value_errors + timeout_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
